//--- verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

  localparam int XLEN         = 32;
  localparam int FETCH_WIDTH  = 3;   // slots looked up per cycle
  localparam int SHIFT_BITS   = 2;   // slots advanced, 0 to 3
  localparam int INDEX_BITS   = 5;
  localparam int TAG_BITS     = 8;   // addr[15:8], space kept below 64 KB
  localparam int MEM_TAG_BITS = 4;   // zero means no transaction

  localparam int NUM_LINES    = 1 << INDEX_BITS;
  localparam int OFFSET_BITS  = 3;   // byte offset in an 8-byte line
  localparam int WORD_SEL     = 2;   // picks upper or lower word of a line
  localparam int INDEX_LSB    = OFFSET_BITS;
  localparam int TAG_LSB      = INDEX_LSB + INDEX_BITS;
  localparam int LINE_MSB     = TAG_LSB + TAG_BITS - 1;
  localparam int LINE_BITS    = TAG_BITS + INDEX_BITS;  // {tag, index}
  localparam int LINE_BYTES   = 1 << OFFSET_BITS;
  localparam int INST_BYTES   = 4;

  // bus command encoding shared with the memory side
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_t;

  typedef logic [63:0] line_t;
  typedef logic [31:0] inst_t;

endpackage

`default_nettype wire

//--- verilog/icache_intf.sv
`default_nettype none

// three lookups answered in the same cycle
interface cache_read_if;
  import icache_pkg::*;

  logic [FETCH_WIDTH-1:0][INDEX_BITS-1:0] index;
  logic [FETCH_WIDTH-1:0][TAG_BITS-1:0]   tag;
  line_t [FETCH_WIDTH-1:0]                data;   // line at each index
  logic [FETCH_WIDTH-1:0]                 hit;    // valid and tag match

  modport lookup (
    output index,
    output tag,
    input  data,
    input  hit
  );

  modport array (
    input  index,
    input  tag,
    output data,
    output hit
  );

endinterface

// single fill port into the arrays
interface cache_write_if;
  import icache_pkg::*;

  logic                  enable;
  logic [INDEX_BITS-1:0] index;
  logic [TAG_BITS-1:0]   tag;
  line_t                 data;

  modport source (
    output enable,
    output index,
    output tag,
    output data
  );

  modport array (
    input enable,
    input index,
    input tag,
    input data
  );

endinterface

`default_nettype wire

//--- verilog/icache_mem.sv
`default_nettype none

module icache_mem (
  input logic          clock,
  input logic          reset,
  cache_read_if.array  rd,
  cache_write_if.array wr
);
  import icache_pkg::*;

  line_t               data_array [NUM_LINES];
  logic [TAG_BITS-1:0] tag_array  [NUM_LINES];
  logic [NUM_LINES-1:0] valid_array;

  // read ports, no clock in the path
  always_comb begin
    for (int p = 0; p < FETCH_WIDTH; p++) begin
      rd.data[p] = data_array[rd.index[p]];
      rd.hit[p]  = valid_array[rd.index[p]] &&
                   (tag_array[rd.index[p]] == rd.tag[p]);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_array <= '0;  // empty cache
    end else if (wr.enable) begin
      valid_array[wr.index] <= 1'b1;
    end
  end

  // line and tag land together, hit from next cycle
  always_ff @(posedge clock) begin
    if (wr.enable) begin
      data_array[wr.index] <= wr.data;
      tag_array[wr.index]  <= wr.tag;
    end
  end

  // the fill index comes from the controller or the prefetch table
  a_wr_index_known: assert property (
    @(posedge clock) disable iff (reset)
    wr.enable |-> !$isunknown(wr.index)
  );

endmodule

`default_nettype wire

//--- verilog/prefetch.sv
`default_nettype none

module prefetch #(
  parameter int PREFETCH_LINES = 4
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0]  mem_response,  // already masked by d_request
  input  logic [icache_pkg::MEM_TAG_BITS-1:0]  mem_tag,
  input  logic                                 give_way,
  input  logic                                 branch,
  input  logic [icache_pkg::FETCH_WIDTH-1:0][icache_pkg::XLEN-1:0] fetch_addr,
  input  logic                                 want_to_fetch,
  input  logic [icache_pkg::XLEN-1:0]          demand_addr,
  output logic                                 already_fetched,
  output logic                                 prefetch_load,
  output logic [icache_pkg::XLEN-1:0]          prefetch_addr,
  output logic [icache_pkg::INDEX_BITS-1:0]    prefetch_index,
  output logic [icache_pkg::TAG_BITS-1:0]      prefetch_tag,
  output logic                                 prefetch_wr_enable
);
  import icache_pkg::*;

  localparam int CNT_BITS  = $clog2(PREFETCH_LINES + 1);
  localparam int SLOT_BITS = (PREFETCH_LINES > 1) ? $clog2(PREFETCH_LINES) : 1;

  // walk state
  logic [XLEN-1:0]      next_addr;
  logic [CNT_BITS-1:0]  remaining;
  logic [LINE_BITS-1:0] last_demand;
  logic                 last_demand_valid;

  // outstanding loads, one entry per accepted tag
  logic [PREFETCH_LINES-1:0]                   entry_valid;
  logic [PREFETCH_LINES-1:0][MEM_TAG_BITS-1:0] entry_mtag;
  logic [PREFETCH_LINES-1:0][LINE_BITS-1:0]    entry_line;
  logic [CNT_BITS-1:0]                         outstanding;

  logic [LINE_BITS-1:0] next_line;
  logic [LINE_BITS-1:0] demand_line;
  logic                 start_walk;
  logic                 next_pending;
  logic                 next_in_window;
  logic                 skip_next;
  logic                 accepted;
  logic                 free_found;
  logic                 fill_found;
  logic [SLOT_BITS-1:0] free_slot;
  logic [SLOT_BITS-1:0] fill_slot;

  assign next_line   = next_addr[LINE_MSB:OFFSET_BITS];
  assign demand_line = demand_addr[LINE_MSB:OFFSET_BITS];
  assign start_walk  = want_to_fetch && !(last_demand_valid && last_demand == demand_line);

  always_comb begin
    next_pending    = 1'b0;
    already_fetched = 1'b0;
    free_found      = 1'b0;
    free_slot       = '0;
    fill_found      = 1'b0;
    fill_slot       = '0;
    for (int i = 0; i < PREFETCH_LINES; i++) begin
      if (entry_valid[i] && entry_line[i] == next_line) next_pending = 1'b1;
      if (entry_valid[i] && entry_line[i] == demand_line) already_fetched = want_to_fetch;
      if (!entry_valid[i] && !free_found) begin
        free_found = 1'b1;
        free_slot  = SLOT_BITS'(i);
      end
      if (entry_valid[i] && entry_mtag[i] == mem_tag && !fill_found) begin
        fill_found = 1'b1;  // entry tags are never zero
        fill_slot  = SLOT_BITS'(i);
      end
    end
    next_in_window = 1'b0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if (fetch_addr[s][LINE_MSB:OFFSET_BITS] == next_line) next_in_window = 1'b1;
    end
  end

  // lines in the fetch window are left to the demand path
  assign skip_next     = next_pending || next_in_window;
  assign prefetch_load = (remaining != '0) && !skip_next && free_found && !give_way && !branch;
  assign accepted      = prefetch_load && (mem_response != '0);
  assign prefetch_addr = next_addr;

  assign prefetch_wr_enable             = fill_found;
  assign {prefetch_tag, prefetch_index} = entry_line[fill_slot];

  always_ff @(posedge clock) begin
    if (reset) begin
      remaining         <= '0;
      last_demand_valid <= 1'b0;
    end else if (branch) begin
      remaining         <= '0;    // old stream dropped, fills still land
      last_demand_valid <= 1'b0;
    end else if (start_walk) begin
      remaining         <= CNT_BITS'(PREFETCH_LINES);
      last_demand_valid <= 1'b1;
    end else if (remaining != '0 && (skip_next || accepted)) begin
      remaining <= remaining - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!branch && start_walk) begin
      next_addr   <= demand_addr + XLEN'(LINE_BYTES);  // line after the miss
      last_demand <= demand_line;
    end else if (remaining != '0 && (skip_next || accepted)) begin
      next_addr <= next_addr + XLEN'(LINE_BYTES);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      outstanding <= '0;
    end else begin
      if (fill_found) entry_valid[fill_slot] <= 1'b0;
      if (accepted) entry_valid[free_slot] <= 1'b1;
      outstanding <= outstanding + CNT_BITS'(accepted) - CNT_BITS'(fill_found);
    end
  end

  always_ff @(posedge clock) begin
    if (accepted) begin
      entry_mtag[free_slot] <= mem_response;
      entry_line[free_slot] <= next_line;
    end
  end

  // running count agrees with the table and stays in range
  a_outstanding_bound: assert property (
    @(posedge clock) disable iff (reset)
    (outstanding <= PREFETCH_LINES) && (outstanding == $countones(entry_valid))
  );

endmodule

`default_nettype wire

//--- verilog/icache.sv
`default_nettype none

// slot FETCH_WIDTH-1 holds the oldest instruction, slot 0 the youngest
module icache #(
  parameter int PREFETCH_LINES = 4
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                take_branch,
  input  logic                                d_request,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  input  icache_pkg::line_t                   mem_data,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag,
  input  logic [icache_pkg::SHIFT_BITS-1:0]   shift,
  input  logic [icache_pkg::FETCH_WIDTH-1:0][icache_pkg::XLEN-1:0] fetch_addr,
  output icache_pkg::bus_command_t            mem_command,
  output logic [icache_pkg::XLEN-1:0]         mem_addr,
  output icache_pkg::inst_t [icache_pkg::FETCH_WIDTH-1:0] fetch_data,
  output logic [icache_pkg::FETCH_WIDTH-1:0]  fetch_valid,
  cache_read_if.lookup                        rd,
  cache_write_if.source                       wr
);
  import icache_pkg::*;

  logic [FETCH_WIDTH-1:0][LINE_BITS-1:0] slot_line;
  logic [MEM_TAG_BITS-1:0] real_response;
  logic                    running;
  logic                    miss_any;
  logic [LINE_BITS-1:0]    demand_line;
  logic [XLEN-1:0]         demand_addr;
  logic [XLEN-1:0]         after_last;
  logic                    pend_valid;
  logic [MEM_TAG_BITS-1:0] pend_tag;
  logic [LINE_BITS-1:0]    pend_line;
  logic                    pend_in_window;
  logic [LINE_BITS-1:0]    head_line;
  logic [LINE_BITS-1:0]    head_next;
  logic                    jumped;
  logic                    want_to_fetch;
  logic                    require_load;
  logic                    demand_fill;
  logic                    give_way;
  logic                    already_fetched;
  logic                    prefetch_load;
  logic [XLEN-1:0]         prefetch_addr;
  logic [INDEX_BITS-1:0]   prefetch_index;
  logic [TAG_BITS-1:0]     prefetch_tag;
  logic                    prefetch_wr_enable;

  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slot_line[s]   = fetch_addr[s][LINE_MSB:OFFSET_BITS];
      rd.index[s]    = fetch_addr[s][TAG_LSB-1:INDEX_LSB];
      rd.tag[s]      = fetch_addr[s][LINE_MSB:TAG_LSB];
      fetch_data[s]  = fetch_addr[s][WORD_SEL] ? rd.data[s][63:32] : rd.data[s][31:0];
      fetch_valid[s] = rd.hit[s];
    end
  end

  // ascending scan, so the oldest missing slot wins
  always_comb begin
    miss_any       = 1'b0;
    demand_line    = slot_line[FETCH_WIDTH-1];
    pend_in_window = 1'b0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if (!rd.hit[s]) begin
        miss_any    = 1'b1;
        demand_line = slot_line[s];
      end
      if (slot_line[s] == pend_line) pend_in_window = 1'b1;
    end
  end

  assign demand_addr = {{(XLEN-LINE_MSB-1){1'b0}}, demand_line, {OFFSET_BITS{1'b0}}};
  assign after_last  = fetch_addr[0] + XLEN'(INST_BYTES);

  // where the head should be next cycle if the stream runs straight
  always_comb begin
    if (shift < SHIFT_BITS'(FETCH_WIDTH)) begin
      head_next = slot_line[FETCH_WIDTH - 1 - int'(shift)];
    end else begin
      head_next = after_last[LINE_MSB:OFFSET_BITS];
    end
  end

  assign jumped = running && (slot_line[FETCH_WIDTH-1] != head_line);

  assign real_response = d_request ? '0 : mem_response;  // data side owns the bus
  assign want_to_fetch = running && miss_any && !(pend_valid && pend_line == demand_line);
  assign require_load  = want_to_fetch && !already_fetched;
  assign give_way      = require_load;
  assign demand_fill   = pend_valid && (mem_tag == pend_tag);

  assign mem_command = (require_load || prefetch_load) ? BUS_LOAD : BUS_NONE;
  assign mem_addr    = require_load  ? demand_addr :
                       prefetch_load ? prefetch_addr : '0;

  // demand fill takes the write port first
  assign wr.enable = demand_fill || prefetch_wr_enable;
  assign wr.index  = demand_fill ? pend_line[INDEX_BITS-1:0] : prefetch_index;
  assign wr.tag    = demand_fill ? pend_line[LINE_BITS-1:INDEX_BITS] : prefetch_tag;
  assign wr.data   = mem_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      running    <= 1'b0;
      pend_valid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (require_load && real_response != '0) begin
        pend_valid <= 1'b1;
      end else if (demand_fill || (jumped && !pend_in_window)) begin
        pend_valid <= 1'b0;  // filled, or the stream left this line
      end
    end
  end

  always_ff @(posedge clock) begin
    if (require_load && real_response != '0) begin
      pend_tag  <= real_response;
      pend_line <= demand_line;
    end
    head_line <= head_next;
  end

  prefetch #(
    .PREFETCH_LINES(PREFETCH_LINES)
  ) pf (
    .clock              (clock),
    .reset              (reset),
    .mem_response       (real_response),
    .mem_tag            (mem_tag),
    .give_way           (give_way),
    .branch             (take_branch),
    .fetch_addr         (fetch_addr),
    .want_to_fetch      (want_to_fetch),
    .demand_addr        (demand_addr),
    .already_fetched    (already_fetched),
    .prefetch_load      (prefetch_load),
    .prefetch_addr      (prefetch_addr),
    .prefetch_index     (prefetch_index),
    .prefetch_tag       (prefetch_tag),
    .prefetch_wr_enable (prefetch_wr_enable)
  );

  a_no_store: assert property (
    @(posedge clock) disable iff (reset)
    mem_command != BUS_STORE
  );

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
`default_nettype none

module icache_top #(
  parameter int PREFETCH_LINES = 4
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [icache_pkg::FETCH_WIDTH-1:0][icache_pkg::XLEN-1:0] fetch_addr,
  input  logic [icache_pkg::SHIFT_BITS-1:0]   shift,
  input  logic                                take_branch,
  input  logic                                d_request,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  input  icache_pkg::line_t                   mem_data,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag,
  output icache_pkg::bus_command_t            mem_command,
  output logic [icache_pkg::XLEN-1:0]         mem_addr,
  output icache_pkg::inst_t [icache_pkg::FETCH_WIDTH-1:0] fetch_data,
  output logic [icache_pkg::FETCH_WIDTH-1:0]  fetch_valid
);

  cache_read_if  rd_if ();
  cache_write_if wr_if ();

  icache #(
    .PREFETCH_LINES(PREFETCH_LINES)
  ) ctrl (
    .clock        (clock),
    .reset        (reset),
    .take_branch  (take_branch),
    .d_request    (d_request),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag),
    .shift        (shift),
    .fetch_addr   (fetch_addr),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .fetch_data   (fetch_data),
    .fetch_valid  (fetch_valid),
    .rd           (rd_if.lookup),
    .wr           (wr_if.source)
  );

  icache_mem arrays (
    .clock (clock),
    .reset (reset),
    .rd    (rd_if.array),
    .wr    (wr_if.array)
  );

endmodule

`default_nettype wire

//--- verification/tb_memory.sv
`default_nettype none

module tb_memory (
  input  logic                                clock,
  input  logic                                reset,
  input  icache_pkg::bus_command_t            mem_command,
  input  logic [icache_pkg::XLEN-1:0]         mem_addr,
  input  logic                                refuse,     // drawn by the testbench each cycle
  input  logic                                data_busy,  // data side wants the bus
  output logic                                d_request,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  output icache_pkg::line_t                   mem_data,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag
);
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int LATENCY = 6;

  logic [MEM_TAG_BITS-1:0] next_tag;
  logic [MEM_TAG_BITS-1:0] stage_tag  [LATENCY];  // delay line of accepted loads
  logic [XLEN-1:0]         stage_addr [LATENCY];
  logic                    accepted;

  function automatic inst_t line_word(input logic [XLEN-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ (addr >> 3) ^ 32'h3c6e_f372;
  endfunction

  assign d_request    = data_busy;
  assign mem_response = (mem_command == BUS_LOAD && !refuse) ? next_tag : '0;
  assign accepted     = (mem_command == BUS_LOAD) && (mem_response != '0) && !d_request;

  always_ff @(posedge clock) begin
    if (reset) begin
      next_tag <= 4'd1;
      for (int i = 0; i < LATENCY; i++) begin
        stage_tag[i] <= '0;
      end
    end else begin
      stage_tag[0]  <= accepted ? mem_response : '0;
      stage_addr[0] <= {mem_addr[XLEN-1:3], 3'b000};
      for (int i = 1; i < LATENCY; i++) begin
        stage_tag[i]  <= stage_tag[i-1];
        stage_addr[i] <= stage_addr[i-1];
      end
      if (accepted) next_tag <= (next_tag == '1) ? 4'd1 : next_tag + 1'b1;  // never zero
    end
  end

  // returned line changes on the falling edge
  initial begin
    mem_tag  = '0;
    mem_data = '0;
    forever begin
      @(negedge clock);
      mem_tag  = stage_tag[LATENCY-1];
      mem_data = {line_word(stage_addr[LATENCY-1] + 32'd4), line_word(stage_addr[LATENCY-1])};
    end
  end

endmodule

`default_nettype wire

//--- verification/icache_tb.sv
`default_nettype none

module icache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int PERIOD   = 40;
  localparam int STEPS    = 2000;
  localparam int MAX_WAIT = 60;  // cycles a fetched line may stay invalid

  logic                             clock;
  logic                             reset;
  logic [FETCH_WIDTH-1:0][XLEN-1:0] fetch_addr;
  logic [SHIFT_BITS-1:0]            shift;
  logic                             take_branch;
  logic                             d_request;
  logic [MEM_TAG_BITS-1:0]          mem_response;
  line_t                            mem_data;
  logic [MEM_TAG_BITS-1:0]          mem_tag;
  bus_command_t                     mem_command;
  logic [XLEN-1:0]                  mem_addr;
  inst_t [FETCH_WIDTH-1:0]          fetch_data;
  logic [FETCH_WIDTH-1:0]           fetch_valid;
  logic                             refuse;
  logic                             data_busy;

  integer               seed;
  logic [XLEN-1:0]      pc;
  int                   taken;
  int                   stall;
  int                   prefetch_hits;
  logic                 walk_allowed;   // a miss was seen since the last branch
  logic                 any_miss;
  logic [LINE_BITS-1:0] demand_line;
  logic [LINE_BITS-1:0] prev_head;
  logic [LINE_BITS-1:0] line_of_tag [1 << MEM_TAG_BITS];
  logic [(1 << MEM_TAG_BITS)-1:0] tag_live;
  bit                   prefetched [int];
  bit                   returned [int];  // lines the memory has sent back

  icache_top #(.PREFETCH_LINES(4)) dut0 (
    .clock(clock), .reset(reset), .fetch_addr(fetch_addr), .shift(shift),
    .take_branch(take_branch), .d_request(d_request), .mem_response(mem_response),
    .mem_data(mem_data), .mem_tag(mem_tag), .mem_command(mem_command),
    .mem_addr(mem_addr), .fetch_data(fetch_data), .fetch_valid(fetch_valid)
  );

  tb_memory mem0 (
    .clock(clock), .reset(reset), .mem_command(mem_command), .mem_addr(mem_addr),
    .refuse(refuse), .data_busy(data_busy), .d_request(d_request),
    .mem_response(mem_response), .mem_data(mem_data), .mem_tag(mem_tag)
  );

  function automatic inst_t expected_word(input logic [XLEN-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ (addr >> 3) ^ 32'h3c6e_f372;
  endfunction

  function automatic logic [LINE_BITS-1:0] line_of(input logic [XLEN-1:0] addr);
    return addr[LINE_MSB:OFFSET_BITS];
  endfunction

  function automatic logic line_pending(input logic [LINE_BITS-1:0] line);
    for (int t = 1; t < (1 << MEM_TAG_BITS); t++) begin
      if (tag_live[t] && line_of_tag[t] == line) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input inst_t expected, input inst_t actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_command(input string name, input bus_command_t expected,
                               input bus_command_t actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_valid(input string name, input logic [FETCH_WIDTH-1:0] expected,
                             input logic [FETCH_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // slot FETCH_WIDTH-1 is the oldest instruction
  task automatic set_window();
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      fetch_addr[s] = pc + XLEN'(4 * (FETCH_WIDTH - 1 - s));
    end
  endtask

  task automatic check_idle();
    check_command("mem_command", BUS_NONE, mem_command);
    check_addr("mem_addr", '0, mem_addr);
    check_valid("fetch_valid", '0, fetch_valid);
  endtask

  task automatic check_fetch();
    logic [LINE_BITS-1:0] head;
    any_miss = 1'b0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if (fetch_valid[s]) begin
        if (!returned.exists(int'(line_of(fetch_addr[s])))) begin
          $display("slot %0d valid for line %h that memory never returned",
                   s, line_of(fetch_addr[s]));
          stop_with_failure();
        end
        check_word($sformatf("fetch_data[%0d]", s), expected_word(fetch_addr[s]), fetch_data[s]);
      end else begin
        any_miss    = 1'b1;
        demand_line = line_of(fetch_addr[s]);  // ends on the oldest miss
      end
    end
    stall = fetch_valid[FETCH_WIDTH-1] ? 0 : stall + 1;
    if (stall > MAX_WAIT) begin
      $display("address %h stayed invalid for more than %0d cycles", pc, MAX_WAIT);
      stop_with_failure();
    end
    head = line_of(fetch_addr[FETCH_WIDTH-1]);
    if (head != prev_head && prefetched.exists(int'(head))) begin
      if (fetch_valid[FETCH_WIDTH-1]) prefetch_hits++;  // hit on first use
      prefetched.delete(int'(head));
    end
    prev_head = head;
  endtask

  task automatic check_bus();
    logic is_prefetch;
    is_prefetch = (mem_command == BUS_LOAD) && !(any_miss && line_of(mem_addr) == demand_line);
    if (mem_command == BUS_LOAD && mem_addr[OFFSET_BITS-1:0] != '0) begin
      $display("load address %h is not aligned to a line", mem_addr);
      stop_with_failure();
    end
    if (any_miss && !line_pending(demand_line)) begin
      check_command("mem_command", BUS_LOAD, mem_command);
      check_addr("mem_addr", XLEN'({demand_line, 3'b000}), mem_addr);
    end
    if (is_prefetch && !walk_allowed) begin
      $display("prefetch load for %h with no demand miss since the last branch", mem_addr);
      stop_with_failure();
    end
    if (mem_tag != '0) begin
      returned[int'(line_of_tag[mem_tag])] = 1'b1;  // lands on the coming edge
      tag_live[mem_tag] = 1'b0;
    end
    if (mem_command == BUS_LOAD && mem_response != '0 && !d_request) begin
      tag_live[mem_response]    = 1'b1;
      line_of_tag[mem_response] = line_of(mem_addr);
      if (is_prefetch) prefetched[int'(line_of(mem_addr))] = 1'b1;
    end
    if (any_miss && !take_branch) walk_allowed = 1'b1;
  endtask

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(STEPS * 40 * PERIOD);
    $display("watchdog expired after %0d cycles", STEPS * 40);
    stop_with_failure();
  end

  initial begin
    seed          = 32'hdeaf;
    reset         = 1'b1;
    pc            = '0;
    shift         = '0;
    take_branch   = 1'b0;
    refuse        = 1'b0;
    data_busy     = 1'b0;
    stall         = 0;
    prefetch_hits = 0;
    walk_allowed  = 1'b0;
    tag_live      = '0;
    set_window();
    prev_head = line_of(pc);
    @(negedge clock);
    #1;
    check_idle();
    @(negedge clock);
    reset = 1'b0;
    #1;
    check_idle();
    for (int step = 0; step < STEPS; step++) begin
      @(negedge clock);
      take_branch = 1'b0;
      if (pc >= 32'h0000_f000 || ($random(seed) & 31) == 0) begin
        pc          = $random(seed) & 32'h0000_effc;
        take_branch = 1'b1;
        walk_allowed = 1'b0;
        stall       = 0;
      end else begin
        pc = pc + XLEN'(4 * taken);
      end
      set_window();
      refuse    = (($random(seed) & 3) == 0);
      data_busy = (($random(seed) & 7) == 0);
      #1;
      check_fetch();
      check_bus();
      // leading valid slots, oldest first
      taken = 0;
      for (int s = FETCH_WIDTH - 1; s >= 0; s--) begin
        if (fetch_valid[s] && taken == FETCH_WIDTH - 1 - s) taken++;
      end
      shift = SHIFT_BITS'(taken);
    end
    if (prefetch_hits == 0) begin
      $display("no prefetched line was hit on its first fetch");
      stop_with_failure();
    end else begin
      $display("prefetched lines hit on first fetch: %0d", prefetch_hits);
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/icache_pkg.sv
verilog/icache_intf.sv
verilog/icache_mem.sv
verilog/prefetch.sv
verilog/icache.sv
verilog/icache_top.sv
verification/tb_memory.sv
verification/icache_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := icache_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
